// ==== dv/backend_stim.txt ====
// per pair, line 1: pc_a rd_a1 rd_a2 rd_b1 rd_b2 imm_a imm_b raddr{a1,a2,b1,b2}
// line 2: ctrl_a ctrl_b exp_ctl exp_wdata_a exp_wdata_b exp_pc_br exp_addr exp_store_data
00001000 00000010 00000000 00000100 00000001 00000005 00000000 02000304
01001001 00101002 02010003 00000015 000000ff 00000000 00000000 00000000
00001008 dead0000 dead0000 dead0000 00000007 00000000 00000000 01020100
00501003 00001005 05030003 000000ff 0000001c 00000000 00000000 00000000
00001010 dead0000 dead0000 dead0000 dead0000 00000004 00000000 02000301
01801006 00101007 07060003 00000ff0 000000ea 00000000 00000000 00000000
00001018 00000200 dead0000 dead0000 00000000 00000004 00000000 00070600
01002100 00001000 00001102 00000000 00000ff0 00000000 00000204 000000ea
00001020 fffffff0 00000005 00000200 00000000 00000000 00000004 0a0b0000
00201009 01009208 08092103 00000001 ffffffea 00000000 00000204 00000000
00001028 00000055 00000055 00000300 00000000 00000040 00000010 0c0d0000
00010000 0100360c 00000010 00000000 00000000 00001068 00000000 00000000
00001030 dead0000 00000000 00000240 00000000 00000000 00000002 08000000
0100100a 0100940b 0b0a4103 ffffffea 00000090 00000000 00000242 00000000
00001038 dead0000 00000000 00000010 00000005 00000000 00000000 0a000e0f
0060100d 00054000 000d0011 00000015 00000000 00001040 00000000 00000000

// ==== sources.f ====
+incdir+common
common/backend_pkg.sv
common/fwd_if.sv
source/stage_reg.sv
execute/operand_forward.sv
execute/int_alu.sv
execute/branch_unit.sv
source/mem_stage.sv
source/dual_backend.sv
dv/backend_sva.sv
dv/backend_tb.sv

// ==== Bender.yml ====
package:
  name: dual_backend

sources:
  - include_dirs:
      - common
    files:
      - common/backend_pkg.sv
      - common/fwd_if.sv
      - source/stage_reg.sv
      - execute/operand_forward.sv
      - execute/int_alu.sv
      - execute/branch_unit.sv
      - source/mem_stage.sv
      - source/dual_backend.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - dv/backend_sva.sv
      - dv/backend_tb.sv

// ==== dv/backend_tb.sv ====
`timescale 1ns/100ps
`include "backend_params.svh"

module backend_tb;

    localparam int WORDS = 16;  // stim words per pair

    logic clk = 1'b0;
    logic reset;
    logic [`XLEN-1:0]   EX_pc_a, EX_pc_b, EX_imm_a, EX_imm_b;
    logic [`XLEN-1:0]   EX_rf_rdata_a1, EX_rf_rdata_a2, EX_rf_rdata_b1, EX_rf_rdata_b2;
    logic [`REG_AW-1:0] EX_rf_raddr_a1, EX_rf_raddr_a2, EX_rf_raddr_b1, EX_rf_raddr_b2;
    logic [2:0]         EX_alu_src_sel_a1, EX_alu_src_sel_a2;
    logic [2:0]         EX_alu_src_sel_b1, EX_alu_src_sel_b2;
    logic [11:0]        EX_alu_op_a, EX_alu_op_b;
    logic [3:0]         EX_br_type_a, EX_br_type_b;
    logic               EX_br_pd_a, EX_br_pd_b, EX_rf_we_a, EX_rf_we_b;
    logic [`REG_AW-1:0] EX_rf_waddr_a, EX_rf_waddr_b;
    logic               EX_mem_we_a, EX_mem_we_b;
    logic [2:0]         EX_mem_type_a, EX_mem_type_b;
    logic [1:0]         EX_wb_mux_select_b;
    logic               WB_rf_we_a, WB_rf_we_b;
    logic [`REG_AW-1:0] WB_rf_waddr_a, WB_rf_waddr_b;
    logic [`XLEN-1:0]   WB_rf_wdata_a, WB_rf_wdata_b;
    logic               br, stall, mem_rvalid, mem_wvalid, mem_rready, mem_wready;
    logic [`XLEN-1:0]   pc_br, mem_addr, mem_wdata, mem_rdata;
    logic [2:0]         mem_type;

    logic [31:0] stim [0:255];
    logic [31:0] mem [0:255];    // model data memory indexed by addr[9:2]
    logic [36:0] q_a[$], q_b[$]; // expected {waddr, wdata} per lane
    int          npairs = 0;
    bit          loaded = 1'b0;
    bit          pend = 1'b0;    // access sitting in mem
    bit          pend_store;
    bit          busy = 1'b0;    // readies held low by the model
    logic [31:0] pend_addr, pend_data;
    logic [2:0]  pend_type;
    int          wait_cnt;
    int unsigned seed_dummy;

    dual_backend dut0 (.*);

    bind dual_backend backend_sva sva0 (
        .clk(clk), .reset(reset), .we_a(WB_rf_we_a), .we_b(WB_rf_we_b),
        .rvalid(mem_rvalid), .wvalid(mem_wvalid), .addr(mem_addr), .mtype(mem_type),
        .wdata(mem_wdata), .stall(stall), .br(br)
    );

    always #4 clk = ~clk;  // 8 ns

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // byte lanes picked from the low address bits
    task automatic store_word(input logic [31:0] a, input logic [2:0] t, input logic [31:0] d);
        case (t)
            3'b001:  mem[a[9:2]] = d;
            3'b110:  mem[a[9:2]][a[1:0]*8 +: 8] = d[7:0];
            3'b111:  mem[a[9:2]][a[1]*16 +: 16] = d[15:0];
            default: ;
        endcase
    endtask

    task automatic drive_idle();
        {EX_pc_a, EX_pc_b, EX_imm_a, EX_imm_b} = '0;
        {EX_rf_rdata_a1, EX_rf_rdata_a2, EX_rf_rdata_b1, EX_rf_rdata_b2} = '0;
        {EX_rf_raddr_a1, EX_rf_raddr_a2, EX_rf_raddr_b1, EX_rf_raddr_b2} = '0;
        {EX_alu_src_sel_a1, EX_alu_src_sel_a2, EX_alu_src_sel_b1, EX_alu_src_sel_b2} = '0;
        {EX_alu_op_a, EX_alu_op_b, EX_br_type_a, EX_br_type_b} = '0;
        {EX_br_pd_a, EX_br_pd_b, EX_rf_we_a, EX_rf_we_b, EX_mem_we_a, EX_mem_we_b} = '0;
        {EX_rf_waddr_a, EX_rf_waddr_b, EX_mem_type_a, EX_mem_type_b} = '0;
        EX_wb_mux_select_b = 2'b01;
    endtask

    // ctrl word from the top nibble down is sel1 sel2 alu br flags mtype then a waddr byte
    task automatic drive_pair(input int k);
        logic [31:0] ca, cb, ra;
        ca = stim[k*WORDS+8];
        cb = stim[k*WORDS+9];
        ra = stim[k*WORDS+7];
        EX_pc_a = stim[k*WORDS];
        EX_pc_b = stim[k*WORDS] + 4;
        {EX_rf_rdata_a1, EX_rf_rdata_a2} = {stim[k*WORDS+1], stim[k*WORDS+2]};
        {EX_rf_rdata_b1, EX_rf_rdata_b2} = {stim[k*WORDS+3], stim[k*WORDS+4]};
        {EX_imm_a, EX_imm_b} = {stim[k*WORDS+5], stim[k*WORDS+6]};
        {EX_rf_raddr_a1, EX_rf_raddr_a2} = {ra[28:24], ra[20:16]};
        {EX_rf_raddr_b1, EX_rf_raddr_b2} = {ra[12:8], ra[4:0]};
        EX_alu_src_sel_a1 = 3'b1 << ca[31:28];
        EX_alu_src_sel_a2 = 3'b1 << ca[27:24];
        EX_alu_src_sel_b1 = 3'b1 << cb[31:28];
        EX_alu_src_sel_b2 = 3'b1 << cb[27:24];
        EX_alu_op_a = 12'b1 << ca[23:20];
        EX_alu_op_b = 12'b1 << cb[23:20];
        {EX_br_type_a, EX_br_type_b} = {ca[19:16], cb[19:16]};
        {EX_br_pd_a, EX_mem_we_a, EX_rf_we_a} = ca[14:12];
        {EX_br_pd_b, EX_mem_we_b, EX_rf_we_b} = cb[14:12];
        {EX_mem_type_a, EX_mem_type_b} = {ca[10:8], cb[10:8]};
        {EX_rf_waddr_a, EX_rf_waddr_b} = {ca[4:0], cb[4:0]};
        EX_wb_mux_select_b = cb[15] ? 2'b10 : 2'b01;
    endtask

    task automatic check_request(input int k);
        logic [31:0] e;
        logic        st;
        e = stim[k*WORDS+10];
        st = e[14:12] == 3'b001 || e[14:12] >= 3'b110;  // st.w, st.b, st.h
        check_value("br", br, e[4]);
        if (e[4]) check_value("pc_br", pc_br, stim[k*WORDS+13]);
        check_value("mem_wvalid", mem_wvalid, e[8] & st);
        check_value("mem_rvalid", mem_rvalid, e[8] & ~st);
        if (e[8]) begin
            check_value("mem_addr", mem_addr, stim[k*WORDS+14]);
            check_value("mem_type", mem_type, e[14:12]);
            if (st) check_value("mem_wdata", mem_wdata, stim[k*WORDS+15]);
        end
    endtask

    // cache model latches requests at mid-cycle and answers after the edge
    initial begin
        seed_dummy = $urandom(75);
        forever begin
            @(negedge clk);
            if (!reset) check_value("stall", stall, busy);
            if (!reset && !stall) begin
                if (pend && pend_store) store_word(pend_addr, pend_type, pend_data);
                pend = 1'b0;
                if (mem_rvalid || mem_wvalid) begin
                    pend_addr  = mem_addr;
                    pend_type  = mem_type;
                    pend_data  = mem_wdata;
                    pend_store = mem_wvalid;
                    wait_cnt   = $urandom % 4;  // 0 to 3 wait cycles
                    pend       = 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        #1;
        if (pend && wait_cnt > 0) begin
            {mem_rready, mem_wready} = 2'b00;
            busy = 1'b1;
            wait_cnt--;
        end else begin
            {mem_rready, mem_wready} = 2'b11;
            busy = 1'b0;
            if (pend) mem_rdata = mem[pend_addr[9:2]];
        end
    end

    // scoreboard on the wb ports
    always @(negedge clk) begin
        logic [36:0] exp_w;
        if (!reset && WB_rf_we_a) begin
            if (q_a.size() == 0) begin
                fail_run("unexpected register write on slot A");
            end else begin
                exp_w = q_a.pop_front();
                check_value("WB_rf_waddr_a", WB_rf_waddr_a, exp_w[36:32]);
                check_value("WB_rf_wdata_a", WB_rf_wdata_a, exp_w[31:0]);
            end
        end
        if (!reset && WB_rf_we_b) begin
            if (q_b.size() == 0) begin
                fail_run("unexpected register write on slot B");
            end else begin
                exp_w = q_b.pop_front();
                check_value("WB_rf_waddr_b", WB_rf_waddr_b, exp_w[36:32]);
                check_value("WB_rf_wdata_b", WB_rf_wdata_b, exp_w[31:0]);
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (npairs * 8 + 100) @(posedge clk);
        fail_run("timeout, the pipeline did not drain in time");
    end

    initial begin
        logic [31:0] e;
        reset = 1'b1;
        {mem_rready, mem_wready, mem_rdata} = {2'b11, 32'h0};
        drive_idle();
        for (int i = 0; i < 256; i++) begin
            mem[i] = {~i[7:0], i[7:0], 8'hf0, i[7:0] ^ 8'h85};
        end
        $readmemh("dv/backend_stim.txt", stim);
        while (npairs < 16 && stim[npairs*WORDS] !== 32'bx) npairs++;
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        for (int k = 0; k < npairs; k++) begin
            drive_pair(k);
            @(negedge clk);
            check_request(k);   // first cycle of the pair
            while (stall) @(negedge clk);
            e = stim[k*WORDS+10];
            if (e[0]) q_a.push_back({e[20:16], stim[k*WORDS+11]});
            if (e[1]) q_b.push_back({e[28:24], stim[k*WORDS+12]});
            @(posedge clk);
            #1;
        end
        drive_idle();
        wait (q_a.size() == 0 && q_b.size() == 0);
        repeat (4) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== dv/backend_sva.sv ====
`timescale 1ns/100ps
`include "backend_params.svh"

module backend_sva (
    input logic             clk,
    input logic             reset,
    input logic             we_a,
    input logic             we_b,
    input logic             rvalid,
    input logic             wvalid,
    input logic [`XLEN-1:0] addr,
    input logic [2:0]       mtype,
    input logic [`XLEN-1:0] wdata,
    input logic             stall,
    input logic             br
);

    // wb register cleared by reset
    wb_quiet_after_reset: assert property (@(posedge clk) $past(reset) |-> !we_a && !we_b)
        else $error("wb write enable high right after reset");

    one_access_kind: assert property (@(posedge clk) disable iff (reset) !(rvalid && wvalid))
        else $error("read and write request together");

    // held pair keeps its request steady
    request_held: assert property (@(posedge clk) disable iff (reset)
        $past(stall) |-> $stable({rvalid, wvalid, addr, mtype, wdata}))
        else $error("cache request moved during stall");

    br_single_cycle: assert property (@(posedge clk) disable iff (reset) br |=> !br)
        else $error("br high two cycles in a row");

endmodule

// ==== source/dual_backend.sv ====
`timescale 1ns/100ps
`include "backend_params.svh"

module dual_backend (
    input  logic               clk,
    input  logic               reset,
    // ex stage, both slots
    input  logic [`XLEN-1:0]   EX_pc_a, EX_pc_b,
    input  logic [`XLEN-1:0]   EX_rf_rdata_a1, EX_rf_rdata_a2,
    input  logic [`XLEN-1:0]   EX_rf_rdata_b1, EX_rf_rdata_b2,
    input  logic [`XLEN-1:0]   EX_imm_a, EX_imm_b,
    input  logic [`REG_AW-1:0] EX_rf_raddr_a1, EX_rf_raddr_a2,
    input  logic [`REG_AW-1:0] EX_rf_raddr_b1, EX_rf_raddr_b2,
    input  logic [2:0]         EX_alu_src_sel_a1, EX_alu_src_sel_a2,  // one-hot
    input  logic [2:0]         EX_alu_src_sel_b1, EX_alu_src_sel_b2,
    input  logic [11:0]        EX_alu_op_a, EX_alu_op_b,
    input  logic [3:0]         EX_br_type_a, EX_br_type_b,
    input  logic               EX_br_pd_a, EX_br_pd_b,  // predicted taken
    input  logic               EX_rf_we_a, EX_rf_we_b,
    input  logic [`REG_AW-1:0] EX_rf_waddr_a, EX_rf_waddr_b,
    input  logic               EX_mem_we_a, EX_mem_we_b,
    input  logic [2:0]         EX_mem_type_a, EX_mem_type_b,
    input  logic [1:0]         EX_wb_mux_select_b,  // alu or load
    // regfile write ports
    output logic               WB_rf_we_a, WB_rf_we_b,
    output logic [`REG_AW-1:0] WB_rf_waddr_a, WB_rf_waddr_b,
    output logic [`XLEN-1:0]   WB_rf_wdata_a, WB_rf_wdata_b,
    // to the front end
    output logic               br,
    output logic [`XLEN-1:0]   pc_br,
    output logic               stall,  // hold the ex inputs
    // data cache
    output logic               mem_rvalid, mem_wvalid,
    output logic [`XLEN-1:0]   mem_addr,
    output logic [2:0]         mem_type,
    output logic [`XLEN-1:0]   mem_wdata,
    input  logic               mem_rready, mem_wready,
    input  logic [`XLEN-1:0]   mem_rdata
);
    import backend_pkg::*;

    logic [`XLEN-1:0] opnd_a1, opnd_a2, opnd_b1, opnd_b2;  // bypassed operands
    logic [`XLEN-1:0] alu_res_a, alu_res_b;
    logic             kill_b;
    ex_mem_t          ex_pkt, mem_pkt;
    mem_wb_t          wb_pkt, wb_q;

    fwd_if fwd_bus ();

    assign fwd_bus.wb_a = wb_q.wb_a;
    assign fwd_bus.wb_b = wb_q.wb_b;

    operand_forward u_fwd (
        .rdata_a1(EX_rf_rdata_a1), .rdata_a2(EX_rf_rdata_a2),
        .rdata_b1(EX_rf_rdata_b1), .rdata_b2(EX_rf_rdata_b2),
        .raddr_a1(EX_rf_raddr_a1), .raddr_a2(EX_rf_raddr_a2),
        .raddr_b1(EX_rf_raddr_b1), .raddr_b2(EX_rf_raddr_b2),
        .fwd(fwd_bus.sink),
        .fwd_a1(opnd_a1), .fwd_a2(opnd_a2), .fwd_b1(opnd_b1), .fwd_b2(opnd_b2)
    );

    int_alu u_alu_a (
        .pc(EX_pc_a), .rdata1(opnd_a1), .rdata2(opnd_a2), .imm(EX_imm_a),
        .src_sel1(src_sel_e'(EX_alu_src_sel_a1)), .src_sel2(src_sel_e'(EX_alu_src_sel_a2)),
        .alu_op(alu_op_e'(EX_alu_op_a)), .result(alu_res_a)
    );

    int_alu u_alu_b (
        .pc(EX_pc_b), .rdata1(opnd_b1), .rdata2(opnd_b2), .imm(EX_imm_b),
        .src_sel1(src_sel_e'(EX_alu_src_sel_b1)), .src_sel2(src_sel_e'(EX_alu_src_sel_b2)),
        .alu_op(alu_op_e'(EX_alu_op_b)), .result(alu_res_b)
    );

    branch_unit u_br (
        .clk, .reset, .stall,
        .pc_a(EX_pc_a), .pc_b(EX_pc_b),
        .rdata_a1(opnd_a1), .rdata_a2(opnd_a2), .rdata_b1(opnd_b1), .rdata_b2(opnd_b2),
        .imm_a(EX_imm_a), .imm_b(EX_imm_b),
        .br_type_a(br_type_e'(EX_br_type_a)), .br_type_b(br_type_e'(EX_br_type_b)),
        .br_pd_a(EX_br_pd_a), .br_pd_b(EX_br_pd_b),
        .kill_b, .br, .pc_br
    );

    mem_stage u_mem (
        .alu_result_a(alu_res_a), .alu_result_b(alu_res_b),
        .rf_we_a(EX_rf_we_a), .rf_we_b(EX_rf_we_b),
        .rf_waddr_a(EX_rf_waddr_a), .rf_waddr_b(EX_rf_waddr_b),
        .mem_we_a(EX_mem_we_a), .mem_we_b(EX_mem_we_b),
        .mem_type_a(mem_type_e'(EX_mem_type_a)), .mem_type_b(mem_type_e'(EX_mem_type_b)),
        .wb_sel_b(wb_sel_e'(EX_wb_mux_select_b)),
        .rdata_a2(opnd_a2), .rdata_b2(opnd_b2), .kill_b,
        .ex_pkt, .mem_rvalid, .mem_wvalid, .mem_addr, .mem_type(mem_type), .mem_wdata,
        .stall, .mem_pkt, .mem_rdata, .mem_rready, .mem_wready, .wb_pkt,
        .fwd(fwd_bus.source)
    );

    // ex/mem freezes while the cache is busy
    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk, .reset, .hold(stall), .bubble(1'b0), .d(ex_pkt), .q(mem_pkt)
    );

    // mem/wb takes a bubble instead, so no write repeats
    stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk, .reset, .hold(1'b0), .bubble(stall), .d(wb_pkt), .q(wb_q)
    );

    assign WB_rf_we_a    = wb_q.wb_a.we;
    assign WB_rf_we_b    = wb_q.wb_b.we;
    assign WB_rf_waddr_a = wb_q.wb_a.waddr;
    assign WB_rf_waddr_b = wb_q.wb_b.waddr;
    assign WB_rf_wdata_a = wb_q.wb_a.wdata;
    assign WB_rf_wdata_b = wb_q.wb_b.wdata;

endmodule

// ==== source/mem_stage.sv ====
`timescale 1ns/100ps
`include "backend_params.svh"

module mem_stage (
    input  logic [`XLEN-1:0]       alu_result_a,
    input  logic [`XLEN-1:0]       alu_result_b,
    input  logic                   rf_we_a,
    input  logic                   rf_we_b,
    input  logic [`REG_AW-1:0]     rf_waddr_a,
    input  logic [`REG_AW-1:0]     rf_waddr_b,
    input  logic                   mem_we_a,
    input  logic                   mem_we_b,
    input  backend_pkg::mem_type_e mem_type_a,
    input  backend_pkg::mem_type_e mem_type_b,
    input  backend_pkg::wb_sel_e   wb_sel_b,
    input  logic [`XLEN-1:0]       rdata_a2,   // store data, bypassed
    input  logic [`XLEN-1:0]       rdata_b2,
    input  logic                   kill_b,
    output backend_pkg::ex_mem_t   ex_pkt,
    output logic                   mem_rvalid,
    output logic                   mem_wvalid,
    output logic [`XLEN-1:0]       mem_addr,
    output backend_pkg::mem_type_e mem_type,
    output logic [`XLEN-1:0]       mem_wdata,
    output logic                   stall,
    input  backend_pkg::ex_mem_t   mem_pkt,
    input  logic [`XLEN-1:0]       mem_rdata,
    input  logic                   mem_rready,
    input  logic                   mem_wready,
    output backend_pkg::mem_wb_t   wb_pkt,
    fwd_if.source                  fwd
);
    import backend_pkg::*;

    logic             a_is_mem;
    logic [`XLEN-1:0] byte_shift;  // addressed byte moved to the bottom
    logic [15:0]      ld_half;
    logic [`XLEN-1:0] ld_data;

    // ex side, request goes out combinationally
    assign a_is_mem   = mem_type_a != MT_LD_W;  // a never loads, nonzero means a store
    assign mem_addr   = a_is_mem ? alu_result_a : alu_result_b;
    assign mem_wdata  = a_is_mem ? rdata_a2 : rdata_b2;
    assign mem_type   = mem_type_e'(mem_type_a + mem_type_b);  // one slot at most
    assign mem_wvalid = mem_we_a | (mem_we_b & ~kill_b);
    assign mem_rvalid = wb_sel_b == WB_LOAD;
    assign stall      = ~(mem_rready | mem_wready);  // both low while cache busy

    assign ex_pkt.lane_a   = '{we: rf_we_a, waddr: rf_waddr_a, wdata: alu_result_a};
    assign ex_pkt.lane_b   = '{we: rf_we_b & ~kill_b, waddr: rf_waddr_b, wdata: alu_result_b};
    assign ex_pkt.ld_type  = mem_type_b;
    assign ex_pkt.addr_lo  = alu_result_b[1:0];
    assign ex_pkt.wb_sel_b = wb_sel_b;

    // mem side, little-endian extract
    assign byte_shift = mem_rdata >> {mem_pkt.addr_lo, 3'b000};
    assign ld_half    = mem_pkt.addr_lo[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    always_comb begin
        case (mem_pkt.ld_type)
            MT_LD_B:  ld_data = {{(`XLEN-8){byte_shift[7]}}, byte_shift[7:0]};
            MT_LD_H:  ld_data = {{(`XLEN-16){ld_half[15]}}, ld_half};
            MT_LD_BU: ld_data = {{(`XLEN-8){1'b0}}, byte_shift[7:0]};
            MT_LD_HU: ld_data = {{(`XLEN-16){1'b0}}, ld_half};
            default:  ld_data = mem_rdata;  // ld.w
        endcase
    end

    assign wb_pkt.wb_a = mem_pkt.lane_a;
    assign wb_pkt.wb_b = '{we:    mem_pkt.lane_b.we,
                           waddr: mem_pkt.lane_b.waddr,
                           wdata: (mem_pkt.wb_sel_b == WB_LOAD) ? ld_data
                                                                : mem_pkt.lane_b.wdata};

    // mem lanes bypass with the final write data, load result included
    assign fwd.mem_a = wb_pkt.wb_a;
    assign fwd.mem_b = wb_pkt.wb_b;

endmodule

// ==== execute/branch_unit.sv ====
`timescale 1ns/100ps
`include "backend_params.svh"

module branch_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic [`XLEN-1:0]      pc_a,
    input  logic [`XLEN-1:0]      pc_b,
    input  logic [`XLEN-1:0]      rdata_a1,
    input  logic [`XLEN-1:0]      rdata_a2,
    input  logic [`XLEN-1:0]      rdata_b1,
    input  logic [`XLEN-1:0]      rdata_b2,
    input  logic [`XLEN-1:0]      imm_a,
    input  logic [`XLEN-1:0]      imm_b,
    input  backend_pkg::br_type_e br_type_a,
    input  backend_pkg::br_type_e br_type_b,
    input  logic                  br_pd_a,  // 1 = predicted taken
    input  logic                  br_pd_b,
    output logic                  kill_b,
    output logic                  br,
    output logic [`XLEN-1:0]      pc_br
);
    import backend_pkg::*;

    logic             taken_a;
    logic             taken_b;
    logic             mis_a;
    logic             mis_b;
    logic [`XLEN-1:0] tgt_a;
    logic [`XLEN-1:0] tgt_b;
    logic             stall_q;  // stall seen last cycle

    function automatic logic taken_of(
        input br_type_e         t,
        input logic [`XLEN-1:0] rs1,
        input logic [`XLEN-1:0] rs2
    );
        case (t)
            BR_BEQ:        return rs1 == rs2;
            BR_BNE:        return rs1 != rs2;
            BR_BLT:        return $signed(rs1) < $signed(rs2);
            BR_BGE:        return $signed(rs1) >= $signed(rs2);
            BR_BLTU:       return rs1 < rs2;
            BR_BGEU:       return rs1 >= rs2;
            BR_B, BR_JIRL: return 1'b1;
            default:       return 1'b0;  // not a branch
        endcase
    endfunction

    // corrected pc, fall-through when not taken
    function automatic logic [`XLEN-1:0] target_of(
        input br_type_e         t,
        input logic             taken,
        input logic [`XLEN-1:0] pc,
        input logic [`XLEN-1:0] rs1,
        input logic [`XLEN-1:0] imm
    );
        if (!taken) begin
            return pc + 4;
        end
        return (t == BR_JIRL) ? rs1 + imm : pc + imm;
    endfunction

    assign taken_a = taken_of(br_type_a, rdata_a1, rdata_a2);
    assign taken_b = taken_of(br_type_b, rdata_b1, rdata_b2);
    assign mis_a   = taken_a != br_pd_a;
    assign mis_b   = taken_b != br_pd_b;
    assign tgt_a   = target_of(br_type_a, taken_a, pc_a, rdata_a1, imm_a);
    assign tgt_b   = target_of(br_type_b, taken_b, pc_b, rdata_b1, imm_b);

    always_ff @(posedge clk) begin
        if (reset) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= stall;
        end
    end

    assign kill_b = mis_a;  // b sits on the wrong path
    // a held pair only reports on its first cycle
    assign br     = (mis_a | mis_b) & ~stall_q;
    assign pc_br  = mis_a ? tgt_a : tgt_b;  // older slot first

endmodule

// ==== execute/int_alu.sv ====
`timescale 1ns/100ps
`include "backend_params.svh"

module int_alu (
    input  logic [`XLEN-1:0]      pc,
    input  logic [`XLEN-1:0]      rdata1,  // already bypassed
    input  logic [`XLEN-1:0]      rdata2,
    input  logic [`XLEN-1:0]      imm,
    input  backend_pkg::src_sel_e src_sel1,
    input  backend_pkg::src_sel_e src_sel2,
    input  backend_pkg::alu_op_e  alu_op,
    output logic [`XLEN-1:0]      result
);
    import backend_pkg::*;

    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic [4:0]       shamt;  // low five bits only

    always_comb begin
        case (src_sel1)
            SRC_PC_IMM: op1 = pc;       // pcaddu12i, bl link
            default:    op1 = rdata1;
        endcase
        case (src_sel2)
            SRC_PC_IMM: op2 = imm;
            SRC_FOUR:   op2 = 4;        // return address pc+4
            default:    op2 = rdata2;
        endcase
    end

    assign shamt = op2[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:   result = op1 + op2;
            ALU_SUB:   result = op1 - op2;
            ALU_SLT:   result = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            ALU_SLTU:  result = {{(`XLEN-1){1'b0}}, op1 < op2};
            ALU_AND:   result = op1 & op2;
            ALU_OR:    result = op1 | op2;
            ALU_NOR:   result = ~(op1 | op2);
            ALU_XOR:   result = op1 ^ op2;
            ALU_SLL:   result = op1 << shamt;
            ALU_SRL:   result = op1 >> shamt;
            ALU_SRA:   result = $signed(op1) >>> shamt;  // keeps the sign
            ALU_LU12I: result = op2;  // decode did the shift
            default:   result = '0;   // no op selected
        endcase
    end

endmodule

// ==== execute/operand_forward.sv ====
`timescale 1ns/100ps
`include "backend_params.svh"

module operand_forward (
    input  logic [`XLEN-1:0]   rdata_a1,
    input  logic [`XLEN-1:0]   rdata_a2,
    input  logic [`XLEN-1:0]   rdata_b1,
    input  logic [`XLEN-1:0]   rdata_b2,
    input  logic [`REG_AW-1:0] raddr_a1,
    input  logic [`REG_AW-1:0] raddr_a2,
    input  logic [`REG_AW-1:0] raddr_b1,
    input  logic [`REG_AW-1:0] raddr_b2,
    fwd_if.sink                fwd,
    output logic [`XLEN-1:0]   fwd_a1,
    output logic [`XLEN-1:0]   fwd_a2,
    output logic [`XLEN-1:0]   fwd_b1,
    output logic [`XLEN-1:0]   fwd_b2
);
    import backend_pkg::*;

    wb_lane_t lanes [4];  // index 0 is the youngest producer

    // walk oldest to youngest so the youngest match is left standing
    function automatic logic [`XLEN-1:0] bypass(
        input logic [`REG_AW-1:0] raddr,
        input logic [`XLEN-1:0]   rdata,
        input wb_lane_t           lane [4]
    );
        logic [`XLEN-1:0] val;
        val = rdata;  // regfile value if nothing in flight
        for (int i = 3; i >= 0; i--) begin
            if (lane[i].we && lane[i].waddr == raddr && raddr != '0) begin
                val = lane[i].wdata;  // r0 is never bypassed
            end
        end
        return val;
    endfunction

    assign lanes[0] = fwd.mem_b;  // b is younger than a in the same pair
    assign lanes[1] = fwd.mem_a;
    assign lanes[2] = fwd.wb_b;
    assign lanes[3] = fwd.wb_a;

    assign fwd_a1 = bypass(raddr_a1, rdata_a1, lanes);
    assign fwd_a2 = bypass(raddr_a2, rdata_a2, lanes);
    assign fwd_b1 = bypass(raddr_b1, rdata_b1, lanes);
    assign fwd_b2 = bypass(raddr_b2, rdata_b2, lanes);

endmodule

// ==== source/stage_reg.sv ====
`timescale 1ns/100ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     hold,    // keep current contents
    input  logic     bubble,  // load an empty slot, wins over hold
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (reset || bubble) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// ==== common/fwd_if.sv ====
`timescale 1ns/100ps

interface fwd_if;
    import backend_pkg::*;

    wb_lane_t mem_a;  // lanes leaving the mem stage
    wb_lane_t mem_b;
    wb_lane_t wb_a;   // registered wb lanes
    wb_lane_t wb_b;

    // mem stage and wb register side
    modport source (output mem_a, output mem_b, output wb_a, output wb_b);

    // ex bypass side
    modport sink (input mem_a, input mem_b, input wb_a, input wb_b);

endinterface

// ==== common/backend_pkg.sv ====
package backend_pkg;
`include "backend_params.svh"

    // alu operation, one-hot
    typedef enum logic [11:0] {
        ALU_ADD   = 12'h001,
        ALU_SUB   = 12'h002,
        ALU_SLT   = 12'h004,
        ALU_SLTU  = 12'h008,
        ALU_AND   = 12'h010,
        ALU_OR    = 12'h020,
        ALU_NOR   = 12'h040,
        ALU_XOR   = 12'h080,
        ALU_SLL   = 12'h100,
        ALU_SRL   = 12'h200,
        ALU_SRA   = 12'h400,
        ALU_LU12I = 12'h800   // imm comes in already shifted
    } alu_op_e;

    // operand select, one-hot
    // middle bit picks pc for operand 1, imm for operand 2
    typedef enum logic [2:0] {
        SRC_REG    = 3'b001,
        SRC_PC_IMM = 3'b010,
        SRC_FOUR   = 3'b100   // operand 2 only, link address
    } src_sel_e;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_BEQ  = 4'd1,
        BR_BNE  = 4'd2,
        BR_BLT  = 4'd3,
        BR_BGE  = 4'd4,
        BR_BLTU = 4'd5,
        BR_BGEU = 4'd6,
        BR_B    = 4'd7,       // pc relative, always taken
        BR_JIRL = 4'd8        // rs1 + imm
    } br_type_e;

    // 000 doubles as "no access", so the two slots add up to the active type
    typedef enum logic [2:0] {
        MT_LD_W  = 3'b000,
        MT_ST_W  = 3'b001,
        MT_LD_B  = 3'b010,
        MT_LD_H  = 3'b011,
        MT_LD_BU = 3'b100,
        MT_LD_HU = 3'b101,
        MT_ST_B  = 3'b110,
        MT_ST_H  = 3'b111
    } mem_type_e;

    typedef enum logic [1:0] {
        WB_ALU  = 2'b01,
        WB_LOAD = 2'b10
    } wb_sel_e;

    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] waddr;
        logic [`XLEN-1:0]   wdata;
    } wb_lane_t;

    typedef struct packed {
        wb_lane_t  lane_a;    // wdata holds the alu result
        wb_lane_t  lane_b;
        mem_type_e ld_type;   // only slot b loads
        logic [1:0] addr_lo;  // byte offset of the load
        wb_sel_e   wb_sel_b;
    } ex_mem_t;

    typedef struct packed {
        wb_lane_t wb_a;
        wb_lane_t wb_b;
    } mem_wb_t;

endpackage

// ==== common/backend_params.svh ====
`ifndef BACKEND_PARAMS_SVH
`define BACKEND_PARAMS_SVH

// datapath and pc width
`define XLEN 32

// register file address width, 32 gprs
`define REG_AW 5

`endif
